/* dcache_geom_pkg.sv */
// address geometry of the data cache; import to split a byte address into tag, set and offsets
`default_nettype none

package dcache_geom_pkg;

    localparam int ADDR_W = 32;  // byte address
    localparam int TAG_W  = 26;
    localparam int IDX_W  = 3;
    localparam int SETS   = 8;
    localparam int WAYS   = 2;

    // one address word, seen either whole or split into its fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0] tag;
            logic [IDX_W-1:0] idx;
            logic             blkoff;   // word within the block
            logic [1:0]       byteoff;
        } fields;
    } dcache_addr_u;

endpackage

`default_nettype wire

/* dcache_cpu_pkg.sv */
// processor-side data word and SC return values, shared by the cache and its testbench
`default_nettype none

package dcache_cpu_pkg;

    typedef logic [31:0] word_t;

    // result word of a store-conditional
    localparam word_t SC_OK_WORD   = 32'd1;
    localparam word_t SC_FAIL_WORD = 32'd0;

endpackage

`default_nettype wire

/* dcache_sets.sv */
// cache storage for 8 sets x 2 ways: lookup, victim and flush read ports, written by the controller
`default_nettype none
`timescale 1ns/1ps

module dcache_sets (
    input  logic                               CLK,
    input  logic                               nRST,
    input  dcache_geom_pkg::dcache_addr_u      addr,
    input  logic                               word_we,
    input  logic                               word_way,
    input  dcache_cpu_pkg::word_t              word_data,
    input  logic                               fill_we,
    input  logic                               fill_way,
    input  logic                               fill_word,
    input  dcache_cpu_pkg::word_t              fill_data,
    input  logic                               lru_we,
    input  logic                               lru_way,
    input  logic [dcache_geom_pkg::IDX_W-1:0]  flush_idx,
    input  logic                               flush_way,
    output logic                               hit,
    output logic                               hit_way,
    output dcache_cpu_pkg::word_t              rdata,
    output logic                               victim_way,
    output logic                               victim_dirty,
    output logic [dcache_geom_pkg::TAG_W-1:0]  victim_tag,
    output dcache_cpu_pkg::word_t              victim_data0,
    output dcache_cpu_pkg::word_t              victim_data1,
    output logic                               flush_dirty,
    output logic [dcache_geom_pkg::TAG_W-1:0]  flush_tag,
    output dcache_cpu_pkg::word_t              flush_data0,
    output dcache_cpu_pkg::word_t              flush_data1
);
    import dcache_geom_pkg::*;
    import dcache_cpu_pkg::*;

    logic [TAG_W-1:0]           tag_r  [SETS][WAYS];
    word_t                      data_r [SETS][WAYS][2];
    logic [SETS-1:0][WAYS-1:0]  valid_r;
    logic [SETS-1:0][WAYS-1:0]  dirty_r;
    logic [SETS-1:0]            lru_r;      // way to evict next

    logic [IDX_W-1:0]           idx;
    logic [WAYS-1:0]            match;

    assign idx = addr.fields.idx;

    assign match[0] = valid_r[idx][0] && (tag_r[idx][0] == addr.fields.tag);
    assign match[1] = valid_r[idx][1] && (tag_r[idx][1] == addr.fields.tag);

    assign hit     = |match;
    assign hit_way = match[1];
    assign rdata   = data_r[idx][hit_way][addr.fields.blkoff];

    // victim follows lru, only worth writing back if valid and dirty
    assign victim_way   = lru_r[idx];
    assign victim_dirty = valid_r[idx][victim_way] && dirty_r[idx][victim_way];
    assign victim_tag   = tag_r[idx][victim_way];
    assign victim_data0 = data_r[idx][victim_way][0];
    assign victim_data1 = data_r[idx][victim_way][1];

    // second read port for the halt walk
    assign flush_dirty = valid_r[flush_idx][flush_way] && dirty_r[flush_idx][flush_way];
    assign flush_tag   = tag_r[flush_idx][flush_way];
    assign flush_data0 = data_r[flush_idx][flush_way][0];
    assign flush_data1 = data_r[flush_idx][flush_way][1];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_r <= '0;
            dirty_r <= '0;
            lru_r   <= '0;
        end else begin
            if (word_we) begin
                dirty_r[idx][word_way] <= 1'b1;
            end
            if (fill_we && fill_word) begin  // block complete
                valid_r[idx][fill_way] <= 1'b1;
                dirty_r[idx][fill_way] <= 1'b0;
            end
            if (lru_we) begin
                lru_r[idx] <= lru_way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (word_we) begin
            data_r[idx][word_way][addr.fields.blkoff] <= word_data;
        end
        if (fill_we) begin
            data_r[idx][fill_way][fill_word] <= fill_data;
            if (fill_word) begin
                tag_r[idx][fill_way] <= addr.fields.tag;
            end
        end
    end

endmodule

`default_nettype wire

/* dcache_link.sv */
// LL/SC link register; tracks the reserved address and reports whether an SC may succeed
`default_nettype none
`timescale 1ns/1ps

module dcache_link (
    input  logic                          CLK,
    input  logic                          nRST,
    input  dcache_geom_pkg::dcache_addr_u addr,
    input  logic                          dmemREN,
    input  logic                          dmemWEN,
    input  logic                          datomic,
    input  logic                          commit,
    output logic                          sc_ok
);
    import dcache_geom_pkg::*;

    logic [ADDR_W-1:0] link_addr;
    logic              link_valid;
    logic              addr_match;

    assign addr_match = (link_addr == addr.raw);
    assign sc_ok      = link_valid && addr_match;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            link_valid <= 1'b0;
        end else if (commit) begin
            if (dmemREN && datomic) begin
                link_valid <= 1'b1;   // LL
            end else if (dmemWEN && (datomic || addr_match)) begin
                link_valid <= 1'b0;   // SC, or plain store to the link
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (commit && dmemREN && datomic) begin
            link_addr <= addr.raw;
        end
    end

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
// cache controller FSM; answers hits, runs write-back and fill on a miss, flushes on halt
`default_nettype none
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                               CLK,
    input  logic                               nRST,
    input  logic                               dmemREN,
    input  logic                               dmemWEN,
    input  logic                               datomic,
    input  logic                               halt,
    input  dcache_geom_pkg::dcache_addr_u      addr,
    input  dcache_cpu_pkg::word_t              dmemstore,
    input  logic                               hit,
    input  logic                               hit_way,
    input  dcache_cpu_pkg::word_t              rdata,
    input  logic                               victim_way,
    input  logic                               victim_dirty,
    input  logic [dcache_geom_pkg::TAG_W-1:0]  victim_tag,
    input  dcache_cpu_pkg::word_t              victim_data0,
    input  dcache_cpu_pkg::word_t              victim_data1,
    input  logic                               flush_dirty,
    input  logic [dcache_geom_pkg::TAG_W-1:0]  flush_tag,
    input  dcache_cpu_pkg::word_t              flush_data0,
    input  dcache_cpu_pkg::word_t              flush_data1,
    input  logic                               sc_ok,
    input  dcache_cpu_pkg::word_t              dload,
    input  logic                               dwait,
    output logic                               dhit,
    output dcache_cpu_pkg::word_t              dmemload,
    output logic                               flushed,
    output logic                               dREN,
    output logic                               dWEN,
    output logic [dcache_geom_pkg::ADDR_W-1:0] daddr,
    output dcache_cpu_pkg::word_t              dstore,
    output logic                               word_we,
    output logic                               word_way,
    output dcache_cpu_pkg::word_t              word_data,
    output logic                               fill_we,
    output logic                               fill_way,
    output logic                               fill_word,
    output dcache_cpu_pkg::word_t              fill_data,
    output logic                               lru_we,
    output logic                               lru_way,
    output logic [dcache_geom_pkg::IDX_W-1:0]  flush_idx,
    output logic                               flush_way
);
    import dcache_geom_pkg::*;
    import dcache_cpu_pkg::*;

    localparam logic [3:0] idle       = 4'd0;
    localparam logic [3:0] wb0        = 4'd1;
    localparam logic [3:0] wb1        = 4'd2;
    localparam logic [3:0] load0      = 4'd3;
    localparam logic [3:0] load1      = 4'd4;
    localparam logic [3:0] flush_scan = 4'd5;
    localparam logic [3:0] flush0     = 4'd6;
    localparam logic [3:0] flush1     = 4'd7;
    localparam logic [3:0] halted     = 4'd8;

    logic [3:0]       state, next_state;
    logic [IDX_W-1:0] flush_row;
    logic             flush_way_r;
    logic             advance;      // step the walk to the next frame
    logic             last_frame;
    logic             sc;
    dcache_addr_u     bus_addr;

    assign sc         = dmemWEN && datomic;
    assign last_frame = (flush_row == IDX_W'(SETS - 1)) && flush_way_r;
    assign flushed    = (state == halted);
    assign flush_idx  = flush_row;
    assign flush_way  = flush_way_r;
    assign daddr      = bus_addr.raw;
    assign word_data  = dmemstore;
    assign fill_data  = dload;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state       <= idle;
            flush_row   <= '0;
            flush_way_r <= 1'b0;
        end else begin
            state <= next_state;
            if (advance) begin
                flush_way_r <= ~flush_way_r;
                if (flush_way_r) begin
                    flush_row <= flush_row + 1'b1;
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        dhit       = 1'b0;
        dmemload   = '0;
        dREN       = 1'b0;
        dWEN       = 1'b0;
        dstore     = '0;
        word_we    = 1'b0;
        word_way   = hit_way;
        fill_we    = 1'b0;
        fill_way   = victim_way;   // fill replaces the victim
        fill_word  = 1'b0;
        lru_we     = 1'b0;
        lru_way    = ~hit_way;
        advance    = 1'b0;
        bus_addr                = '0;
        bus_addr.fields.tag     = addr.fields.tag;
        bus_addr.fields.idx     = addr.fields.idx;

        case (state)
            idle: begin
                if (halt) begin
                    next_state = flush_scan;
                end else if (sc && !sc_ok) begin
                    dhit     = 1'b1;
                    dmemload = SC_FAIL_WORD;
                end else if ((dmemREN || dmemWEN) && hit) begin
                    dhit     = 1'b1;
                    lru_we   = 1'b1;
                    word_we  = dmemWEN;
                    dmemload = sc ? SC_OK_WORD : rdata;
                end else if (dmemREN || dmemWEN) begin
                    next_state = victim_dirty ? wb0 : load0;
                end
            end
            wb0, wb1: begin
                dWEN                   = 1'b1;
                bus_addr.fields.tag    = victim_tag;
                bus_addr.fields.blkoff = (state == wb1);
                dstore                 = (state == wb1) ? victim_data1 : victim_data0;
                if (!dwait) begin
                    next_state = (state == wb1) ? load0 : wb1;
                end
            end
            load0, load1: begin
                dREN                   = 1'b1;
                bus_addr.fields.blkoff = (state == load1);
                fill_we                = !dwait;
                fill_word              = (state == load1);
                if (!dwait) begin
                    next_state = (state == load1) ? idle : load1;  // retry hits
                end
            end
            flush_scan: begin
                if (flush_dirty) begin
                    next_state = flush0;
                end else begin
                    advance    = 1'b1;
                    next_state = last_frame ? halted : flush_scan;
                end
            end
            flush0, flush1: begin
                dWEN                   = 1'b1;
                bus_addr.fields.tag    = flush_tag;
                bus_addr.fields.idx    = flush_row;
                bus_addr.fields.blkoff = (state == flush1);
                dstore                 = (state == flush1) ? flush_data1 : flush_data0;
                if (!dwait && state == flush0) begin
                    next_state = flush1;
                end else if (!dwait) begin
                    advance    = 1'b1;
                    next_state = last_frame ? halted : flush_scan;
                end
            end
            halted: begin
                next_state = halted;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* dcache.sv */
// data cache top; connects storage, link register and controller between datapath and memory bus
`default_nettype none
`timescale 1ns/1ps

module dcache (
    input  logic                               CLK,
    input  logic                               nRST,
    input  logic                               dmemREN,
    input  logic                               dmemWEN,
    input  logic                               datomic,
    input  logic                               halt,
    input  dcache_geom_pkg::dcache_addr_u      dmemaddr,
    input  dcache_cpu_pkg::word_t              dmemstore,
    output logic                               dhit,
    output dcache_cpu_pkg::word_t              dmemload,
    output logic                               flushed,
    output logic                               dREN,
    output logic                               dWEN,
    output logic [dcache_geom_pkg::ADDR_W-1:0] daddr,
    output dcache_cpu_pkg::word_t              dstore,
    input  dcache_cpu_pkg::word_t              dload,
    input  logic                               dwait
);
    import dcache_geom_pkg::*;
    import dcache_cpu_pkg::*;

    logic             hit, hit_way;
    word_t            rdata;
    logic             victim_way, victim_dirty;
    logic [TAG_W-1:0] victim_tag, flush_tag;
    word_t            victim_data0, victim_data1;
    logic             flush_dirty;
    word_t            flush_data0, flush_data1;
    logic             word_we, word_way, fill_we, fill_way, fill_word;
    word_t            word_data, fill_data;
    logic             lru_we, lru_way;
    logic [IDX_W-1:0] flush_idx;
    logic             flush_way;
    logic             sc_ok;

    dcache_sets i_sets (
        .CLK, .nRST, .addr(dmemaddr),
        .word_we, .word_way, .word_data,
        .fill_we, .fill_way, .fill_word, .fill_data,
        .lru_we, .lru_way, .flush_idx, .flush_way,
        .hit, .hit_way, .rdata,
        .victim_way, .victim_dirty, .victim_tag, .victim_data0, .victim_data1,
        .flush_dirty, .flush_tag, .flush_data0, .flush_data1
    );

    // link commits on the same pulse that completes the request
    dcache_link i_link (
        .CLK, .nRST, .addr(dmemaddr),
        .dmemREN, .dmemWEN, .datomic,
        .commit(dhit), .sc_ok
    );

    dcache_ctrl i_ctrl (
        .CLK, .nRST, .dmemREN, .dmemWEN, .datomic, .halt,
        .addr(dmemaddr), .dmemstore,
        .hit, .hit_way, .rdata,
        .victim_way, .victim_dirty, .victim_tag, .victim_data0, .victim_data1,
        .flush_dirty, .flush_tag, .flush_data0, .flush_data1,
        .sc_ok, .dload, .dwait,
        .dhit, .dmemload, .flushed, .dREN, .dWEN, .daddr, .dstore,
        .word_we, .word_way, .word_data,
        .fill_we, .fill_way, .fill_word, .fill_data,
        .lru_we, .lru_way, .flush_idx, .flush_way
    );

endmodule

`default_nettype wire

/* dcache_sva.sv */
// bus and status assertions for the data cache, bound into every dcache instance
`timescale 1ns/1ps
`default_nettype none

module dcache_sva (
    input logic        CLK,
    input logic        nRST,
    input logic        dREN,
    input logic        dWEN,
    input logic        dwait,
    input logic        dhit,
    input logic        flushed,
    input logic [31:0] daddr,
    input logic [31:0] dstore
);

    a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
        else $error("dREN and dWEN high together");

    // stalled transfer keeps its address and data
    a_hold: assert property (@(posedge CLK) disable iff (!nRST)
        ((dREN || dWEN) && dwait) |=> ($stable(daddr) && $stable(dstore)))
        else $error("bus address or data moved during a stall");

    a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
        else $error("flushed fell");

    a_no_hit_flushed: assert property (@(posedge CLK) disable iff (!nRST) !(dhit && flushed))
        else $error("dhit raised after flush");

endmodule

bind dcache dcache_sva i_sva (
    .CLK(CLK), .nRST(nRST), .dREN(dREN), .dWEN(dWEN), .dwait(dwait),
    .dhit(dhit), .flushed(flushed), .daddr(daddr), .dstore(dstore)
);

`default_nettype wire

/* dcache_checker.sv */
// testbench checker; compares load and SC results at dhit and the flushed memory image
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  dhit,
    input  dcache_cpu_pkg::word_t dmemload,
    input  logic                  dWEN,
    input  logic                  dwait,
    input  logic [31:0]           daddr,
    input  logic                  flushed,
    input  dcache_cpu_pkg::word_t exp_word,
    input  logic                  exp_check,
    input  string                 test_name,
    input  dcache_cpu_pkg::word_t mem [256],
    input  dcache_cpu_pkg::word_t ref_img [256],
    output int                    n_checks,
    output int                    n_errors,
    output logic                  mem_checked
);

    // outputs are stable mid-cycle, so sample on the falling edge
    always @(negedge CLK) begin
        if (!nRST) begin
            n_checks    = 0;
            n_errors    = 0;
            mem_checked = 1'b0;
        end else begin
            if (dhit && exp_check) begin
                n_checks++;
                if (dmemload !== exp_word) begin
                    n_errors++;
                    $display("mismatch %s expected %h actual %h",
                             test_name, exp_word, dmemload);
                end
            end

            if (dWEN && !dwait) begin
                $display("write-back word to %h", daddr);
            end

            if (flushed && !mem_checked) begin
                for (int i = 0; i < 256; i++) begin
                    n_checks++;
                    if (mem[i[7:0]] !== ref_img[i[7:0]]) begin
                        n_errors++;
                        $display("mismatch flush_image word %0d expected %h actual %h",
                                 i, ref_img[i[7:0]], mem[i[7:0]]);
                    end
                end
                mem_checked = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
// testbench top for the data cache; drives requests, models the memory bus and prints the verdict
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_geom_pkg::*;
    import dcache_cpu_pkg::*;

    localparam int          MEM_WORDS  = 256;
    localparam int          N_DIRECTED = 16;
    localparam int          N_RANDOM   = 200;
    localparam int          MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 16 + SETS * WAYS * 6 + 100;
    localparam logic [31:0] SEED       = 32'h35e8_2a98;

    logic         CLK = 1'b0;
    logic         nRST, dmemREN, dmemWEN, datomic, halt, dwait;
    dcache_addr_u dmemaddr;
    word_t        dmemstore, dmemload, dstore, dload;
    logic         dhit, flushed, dREN, dWEN;
    logic [31:0]  daddr;

    word_t        mem [MEM_WORDS];
    word_t        ref_img [MEM_WORDS];
    logic [31:0]  ref_link;
    logic         ref_link_valid;
    word_t        exp_word;
    logic         exp_check;
    string        test_name;
    int           n_checks, n_errors, tb_errors, cycles, wait_left, op;
    logic         xfer_done, saw_dren, mem_checked;
    logic [31:0]  wb_log [$];
    logic [31:0]  rnd_addr;

    always #50 CLK = ~CLK;

    dcache i_dcache (.*);

    dcache_checker i_checker (
        .CLK, .nRST, .dhit, .dmemload, .dWEN, .dwait, .daddr, .flushed,
        .exp_word, .exp_check, .test_name, .mem, .ref_img,
        .n_checks, .n_errors, .mem_checked
    );

    // memory model, word addressed
    assign dload = mem[daddr[9:2]];

    always @(negedge CLK) begin
        xfer_done = nRST && (dREN || dWEN) && !dwait;  // next edge completes
        if (xfer_done && dWEN) begin
            mem[daddr[9:2]] = dstore;
            wb_log.push_back(daddr);
        end
    end

    always @(posedge CLK) begin
        #5;
        if (xfer_done) begin
            wait_left = $urandom_range(2, 0);
        end
        dwait = (dREN || dWEN) && (wait_left > 0);
        if (dwait) begin
            wait_left--;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // expected response from a flat memory image and one link register
    function automatic word_t ref_access(input logic ren, input logic wen, input logic atomic,
                                         input logic [31:0] a, input word_t wdata);
        word_t result;
        result = ref_img[a[9:2]];
        if (ren && atomic) begin
            ref_link       = a;
            ref_link_valid = 1'b1;
        end else if (wen && atomic) begin
            if (ref_link_valid && ref_link == a) begin
                ref_img[a[9:2]] = wdata;
                result          = SC_OK_WORD;
            end else begin
                result = SC_FAIL_WORD;
            end
            ref_link_valid = 1'b0;
        end else if (wen) begin
            ref_img[a[9:2]] = wdata;
            if (ref_link == a) begin
                ref_link_valid = 1'b0;
            end
        end
        return result;
    endfunction

    task automatic do_req(input string name, input logic ren, input logic wen,
                          input logic atomic, input logic [31:0] a, input word_t wdata);
        exp_word     = ref_access(ren, wen, atomic, a, wdata);
        exp_check    = ren || atomic;  // plain stores return nothing useful
        test_name    = name;
        dmemREN      = ren;
        dmemWEN      = wen;
        datomic      = atomic;
        dmemaddr.raw = a;
        dmemstore    = wdata;
        saw_dren     = 1'b0;
        @(negedge CLK);
        while (!dhit) begin
            saw_dren = saw_dren || dREN;
            @(negedge CLK);
        end
        @(posedge CLK);
        #5;
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
        datomic = 1'b0;
    endtask

    task automatic rd(input string name, input logic [31:0] a);
        do_req(name, 1'b1, 1'b0, 1'b0, a, '0);
    endtask

    task automatic wr(input string name, input logic [31:0] a, input word_t d);
        do_req(name, 1'b0, 1'b1, 1'b0, a, d);
    endtask

    task automatic ll(input string name, input logic [31:0] a);
        do_req(name, 1'b1, 1'b0, 1'b1, a, '0);
    endtask

    task automatic sc(input string name, input logic [31:0] a, input word_t d);
        do_req(name, 1'b0, 1'b1, 1'b1, a, d);
    endtask

    initial begin
        void'($urandom(SEED));
        nRST = 1'b0;
        {dmemREN, dmemWEN, datomic, halt, dwait} = '0;
        dmemaddr  = '0;
        dmemstore = '0;
        ref_link  = '0;
        ref_link_valid = 1'b0;
        exp_word  = '0;
        exp_check = 1'b0;
        test_name = "reset";
        tb_errors = 0;
        cycles    = 0;
        wait_left = 0;
        xfer_done = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i[7:0]]     = {i[7:0], ~i[7:0], i[7:0] ^ 8'h3c, 8'ha5};
            ref_img[i[7:0]] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h3c, 8'ha5};
        end
        repeat (5) @(posedge CLK);
        #5 nRST = 1'b1;
        @(negedge CLK);
        if (dhit || dREN || dWEN || flushed) begin
            tb_errors++;
            $display("outputs not idle after reset");
        end
        @(posedge CLK);
        #5;

        rd("first_read", 32'h10);
        if (!saw_dren) begin
            tb_errors++;
            $display("first read after reset completed without a memory read");
        end
        rd("read_again", 32'h10);

        // three tags in set 1, LRU victim is A
        wr("write_a", 32'h108, 32'haaaa_0001);
        wr("write_b", 32'h148, 32'hbbbb_0001);
        wb_log.delete();
        rd("read_c", 32'h188);
        if (wb_log.size() != 2) begin
            tb_errors++;
            $display("expected two write-back words for victim A, saw %0d", wb_log.size());
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (wb_log[i] != 32'h108 + 32'(4 * i)) begin
                    tb_errors++;
                    $display("mismatch victim_order expected %h actual %h",
                             32'h108 + 32'(4 * i), wb_log[i]);
                end
            end
        end
        rd("read_a", 32'h108);
        rd("read_b", 32'h14c);

        ll("ll_ok", 32'h20);
        sc("sc_ok", 32'h20, 32'h5c00_0020);
        rd("read_sc_ok", 32'h20);
        sc("sc_no_link", 32'h24, 32'hdead_0024);
        rd("read_no_sc", 32'h24);
        ll("ll_broken", 32'h28);
        wr("store_link", 32'h28, 32'h1234_0028);
        sc("sc_broken", 32'h28, 32'hdead_0028);
        rd("read_broken", 32'h28);

        for (int n = 0; n < N_RANDOM; n++) begin
            op       = $urandom_range(5, 0);
            rnd_addr = ($urandom_range(3, 0) << 6) | ($urandom_range(7, 0) << 3)
                     | ($urandom_range(1, 0) << 2);
            case (op)
                0, 1:    rd("random_read", rnd_addr);
                2, 3:    wr("random_write", rnd_addr, $urandom);
                4:       ll("random_ll", rnd_addr);
                default: sc("random_sc", rnd_addr, $urandom);
            endcase
        end

        halt = 1'b1;
        @(negedge CLK);
        while (!mem_checked) begin
            @(negedge CLK);
        end

        // a request while flushed stays unanswered
        @(posedge CLK);
        #5;
        dmemREN      = 1'b1;
        dmemaddr.raw = 32'h10;
        repeat (3) begin
            @(negedge CLK);
            if (dhit) begin
                tb_errors++;
                $display("dhit raised for a request after the flush");
            end
        end

        $display("checks %0d, checker errors %0d, testbench errors %0d",
                 n_checks, n_errors, tb_errors);
        if (n_errors + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
dcache_geom_pkg.sv
dcache_cpu_pkg.sv
dcache_sets.sv
dcache_link.sv
dcache_ctrl.sv
dcache.sv
dcache_sva.sv
dcache_checker.sv
tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# builds the data cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dcache \
    -f verilog.f -o sim_dcache > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0
